//--- permPkg.sv
package permPkg;

    // Work words and the input beat
    localparam int WORD_W = 64;
    // Channel A in the upper half, channel B in the lower half
    localparam int IN_W = 2 * WORD_W;

    // Summed sub-fields of a word
    localparam int FIELD_W = 16;
    localparam int NUM_FIELDS = WORD_W / FIELD_W;
    localparam int FIELD_CNT_W = $clog2(FIELD_W + 1);

    // Lane result layout, count above sum
    localparam int COUNT_W = 13;
    localparam int SUM_W = 48;
    localparam int RESULT_W = COUNT_W + SUM_W;

    // Lane banks
    localparam int LANES_PER_CHAN = 2;
    localparam int TOTAL_LANES = 2 * LANES_PER_CHAN;

    // Lane result FIFO
    localparam int LANE_FIFO_LOG2 = 4;
    // Covers the worker pipeline plus selector delay
    localparam int LANE_AF_MARGIN = 6;

    // Origin queue, deep enough for everything the lanes can hold
    localparam int ORIGIN_FIFO_LOG2 = 6;

    // Output FIFO
    localparam int OUT_FIFO_LOG2 = 4;
    localparam int OUT_AF_MARGIN = 3;

endpackage

//--- syncFifo.sv
`timescale 1ns/10ps

module syncFifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH_LOG2 = 4,
    parameter int AF_MARGIN = 2,
    parameter bit ZERO_WHEN_EMPTY = 1'b0
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             wrEn,
    input  logic [WIDTH-1:0] wrData,
    input  logic             rdEn,
    output logic [WIDTH-1:0] rdData,
    output logic             empty,
    output logic             almostFull
);

    logic [WIDTH-1:0] mem [2 ** DEPTH_LOG2];
    logic [DEPTH_LOG2-1:0] wrPtr;
    logic [DEPTH_LOG2-1:0] rdPtr;
    // One extra bit so a full buffer is distinct from an empty one
    logic [DEPTH_LOG2:0] count;

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrPtr] <= wrData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (wrEn) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (rdEn) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({wrEn, rdEn})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign empty = (count == '0);
    assign almostFull = (count >= (DEPTH_LOG2 + 1)'(2 ** DEPTH_LOG2 - AF_MARGIN));

    // Head shows through combinationally, first word fall through
    assign rdData = (ZERO_WHEN_EMPTY && empty) ? '0 : mem[rdPtr];

    noWriteWhenFull: assert property (@(posedge clk) disable iff (rst)
        (wrEn && !rdEn) |-> !count[DEPTH_LOG2])
        else $error("syncFifo: write while full");

    noReadWhenEmpty: assert property (@(posedge clk) disable iff (rst)
        rdEn |-> !empty)
        else $error("syncFifo: read while empty");

endmodule

//--- laneSelector.sv
`timescale 1ns/10ps

module laneSelector #(
    parameter int NUM_LANES = 2
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 accept,
    input  logic [NUM_LANES-1:0] laneAlmostFull,
    output logic [NUM_LANES-1:0] selected
);

    logic [NUM_LANES-1:0] nextSel;
    logic [NUM_LANES-1:0] rotated;

    // Walk from the farthest lane back so the nearest free one wins
    always_comb begin
        nextSel = selected;
        rotated = selected;
        for (int i = NUM_LANES - 1; i > 0; i--) begin
            rotated = (selected << i) | (selected >> (NUM_LANES - i));
            if ((rotated & ~laneAlmostFull) != '0) begin
                nextSel = rotated;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            selected <= NUM_LANES'(1);
        end else if (accept) begin
            selected <= nextSel;
        end
    end

    selectOneHot: assert property (@(posedge clk) disable iff (rst)
        $onehot(selected))
        else $error("laneSelector: selection not one-hot");

endmodule

//--- laneWorker.sv
`timescale 1ns/10ps

module laneWorker (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          wrEn,
    input  logic [permPkg::WORD_W-1:0]    word,
    input  logic                          rdEn,
    output logic [permPkg::RESULT_W-1:0]  result,
    output logic                          empty,
    output logic                          almostFull
);

    // Stage one, fields and their one counts
    logic                               valid1;
    logic [permPkg::WORD_W-1:0]         word1;
    logic [permPkg::FIELD_CNT_W-1:0]    partial1 [permPkg::NUM_FIELDS];
    // Stage two, count and sum
    logic                               valid2;
    logic [permPkg::COUNT_W-1:0]        count2;
    logic [permPkg::SUM_W-1:0]          sum2;
    // Stage three, packed result
    logic                               valid3;
    logic [permPkg::RESULT_W-1:0]       packed3;
    logic [permPkg::COUNT_W-1:0]        countSum;
    logic [permPkg::SUM_W-1:0]          fieldSum;

    function automatic logic [permPkg::FIELD_CNT_W-1:0] fieldOnes(
        input logic [permPkg::FIELD_W-1:0] field
    );
        logic [permPkg::FIELD_CNT_W-1:0] total;
        total = '0;
        for (int b = 0; b < permPkg::FIELD_W; b++) begin
            total = total + {{(permPkg::FIELD_CNT_W - 1){1'b0}}, field[b]};
        end
        return total;
    endfunction

    always_comb begin
        countSum = '0;
        fieldSum = '0;
        for (int f = 0; f < permPkg::NUM_FIELDS; f++) begin
            countSum = countSum
                + {{(permPkg::COUNT_W - permPkg::FIELD_CNT_W){1'b0}}, partial1[f]};
            fieldSum = fieldSum
                + {{(permPkg::SUM_W - permPkg::FIELD_W){1'b0}},
                   word1[f*permPkg::FIELD_W +: permPkg::FIELD_W]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid1 <= 1'b0;
            valid2 <= 1'b0;
            valid3 <= 1'b0;
        end else begin
            valid1 <= wrEn;
            valid2 <= valid1;
            valid3 <= valid2;
        end
    end

    always_ff @(posedge clk) begin
        word1 <= word;
        for (int f = 0; f < permPkg::NUM_FIELDS; f++) begin
            partial1[f] <= fieldOnes(word[f*permPkg::FIELD_W +: permPkg::FIELD_W]);
        end
        count2 <= countSum;
        sum2 <= fieldSum;
        packed3 <= {count2, sum2};
    end

    // Zero while empty so idle lanes drop out of the channel OR
    syncFifo #(
        .WIDTH(permPkg::RESULT_W),
        .DEPTH_LOG2(permPkg::LANE_FIFO_LOG2),
        .AF_MARGIN(permPkg::LANE_AF_MARGIN),
        .ZERO_WHEN_EMPTY(1'b1)
    ) u_resultFifo (
        .clk(clk),
        .rst(rst),
        .wrEn(valid3),
        .wrData(packed3),
        .rdEn(rdEn),
        .rdData(result),
        .empty(empty),
        .almostFull(almostFull)
    );

endmodule

//--- laneArray.sv
`timescale 1ns/10ps

module laneArray (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          accept,
    input  logic [permPkg::WORD_W-1:0]    wordA,
    input  logic [permPkg::WORD_W-1:0]    wordB,
    output logic                          full,
    input  logic                          hold,
    output logic                          resultValid,
    output logic [permPkg::RESULT_W-1:0]  resultA,
    output logic [permPkg::RESULT_W-1:0]  resultB
);

    // Channel A owns the low lanes, channel B the high lanes
    logic [permPkg::LANES_PER_CHAN-1:0] selA;
    logic [permPkg::LANES_PER_CHAN-1:0] selB;
    logic [permPkg::TOTAL_LANES-1:0]    laneWrite;
    logic [permPkg::TOTAL_LANES-1:0]    laneRead;
    logic [permPkg::TOTAL_LANES-1:0]    laneEmpty;
    logic [permPkg::TOTAL_LANES-1:0]    laneAlmostFull;
    logic [permPkg::TOTAL_LANES-1:0]    originHead;
    logic                               originEmpty;
    logic                               gather;
    logic [permPkg::RESULT_W-1:0]       laneResult [permPkg::TOTAL_LANES];
    logic [permPkg::RESULT_W-1:0]       orA;
    logic [permPkg::RESULT_W-1:0]       orB;

    laneSelector #(
        .NUM_LANES(permPkg::LANES_PER_CHAN)
    ) u_selA (
        .clk(clk),
        .rst(rst),
        .accept(accept),
        .laneAlmostFull(laneAlmostFull[permPkg::LANES_PER_CHAN-1:0]),
        .selected(selA)
    );

    laneSelector #(
        .NUM_LANES(permPkg::LANES_PER_CHAN)
    ) u_selB (
        .clk(clk),
        .rst(rst),
        .accept(accept),
        .laneAlmostFull(laneAlmostFull[permPkg::TOTAL_LANES-1:permPkg::LANES_PER_CHAN]),
        .selected(selB)
    );

    assign laneWrite = accept ? {selB, selA} : '0;
    assign full = (&laneAlmostFull[permPkg::LANES_PER_CHAN-1:0])
        || (&laneAlmostFull[permPkg::TOTAL_LANES-1:permPkg::LANES_PER_CHAN]);

    // Remembers which lanes took each item, in input order
    syncFifo #(
        .WIDTH(permPkg::TOTAL_LANES),
        .DEPTH_LOG2(permPkg::ORIGIN_FIFO_LOG2),
        .AF_MARGIN(1)
    ) u_originQueue (
        .clk(clk),
        .rst(rst),
        .wrEn(accept),
        .wrData({selB, selA}),
        .rdEn(gather),
        .rdData(originHead),
        .empty(originEmpty),
        .almostFull()
    );

    // Wait until every lane named by the head entry has its result
    assign gather = !originEmpty && ((originHead & laneEmpty) == '0) && !hold;
    assign laneRead = gather ? originHead : '0;

    for (genvar i = 0; i < permPkg::TOTAL_LANES; i++) begin : g_lane
        laneWorker u_laneWorker (
            .clk(clk),
            .rst(rst),
            .wrEn(laneWrite[i]),
            .word((i < permPkg::LANES_PER_CHAN) ? wordA : wordB),
            .rdEn(laneRead[i]),
            .result(laneResult[i]),
            .empty(laneEmpty[i]),
            .almostFull(laneAlmostFull[i])
        );
    end

    // Only the popped lane of each channel contributes
    always_comb begin
        orA = '0;
        orB = '0;
        for (int i = 0; i < permPkg::LANES_PER_CHAN; i++) begin
            orA = orA | (laneResult[i] & {permPkg::RESULT_W{laneRead[i]}});
            orB = orB | (laneResult[i + permPkg::LANES_PER_CHAN]
                & {permPkg::RESULT_W{laneRead[i + permPkg::LANES_PER_CHAN]}});
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resultValid <= 1'b0;
        end else begin
            resultValid <= gather;
        end
    end

    always_ff @(posedge clk) begin
        resultA <= orA;
        resultB <= orB;
    end

    noAcceptWhenFull: assert property (@(posedge clk) disable iff (rst)
        accept |-> !full)
        else $error("laneArray: item accepted while a channel is full");

endmodule

//--- permDispatchTop.sv
`timescale 1ns/10ps

module permDispatchTop (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          inValid,
    output logic                          inReady,
    input  logic [permPkg::IN_W-1:0]      inData,
    output logic                          outValid,
    input  logic                          outReady,
    output logic [permPkg::RESULT_W-1:0]  outResultA,
    output logic [permPkg::RESULT_W-1:0]  outResultB
);

    logic                             running;
    logic                             accept;
    logic                             full;
    logic                             hold;
    logic                             resultValid;
    logic                             outEmpty;
    logic [permPkg::RESULT_W-1:0]     resultA;
    logic [permPkg::RESULT_W-1:0]     resultB;
    logic [2*permPkg::RESULT_W-1:0]   outPair;

    // Comes up one cycle after reset releases
    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
        end else begin
            running <= 1'b1;
        end
    end

    assign inReady = running && !full;
    assign accept = inValid && inReady;

    laneArray u_laneArray (
        .clk(clk),
        .rst(rst),
        .accept(accept),
        .wordA(inData[permPkg::IN_W-1:permPkg::WORD_W]),
        .wordB(inData[permPkg::WORD_W-1:0]),
        .full(full),
        .hold(hold),
        .resultValid(resultValid),
        .resultA(resultA),
        .resultB(resultB)
    );

    // Almost full stops gathering before the buffer overflows
    syncFifo #(
        .WIDTH(2 * permPkg::RESULT_W),
        .DEPTH_LOG2(permPkg::OUT_FIFO_LOG2),
        .AF_MARGIN(permPkg::OUT_AF_MARGIN)
    ) u_outFifo (
        .clk(clk),
        .rst(rst),
        .wrEn(resultValid),
        .wrData({resultA, resultB}),
        .rdEn(outValid && outReady),
        .rdData(outPair),
        .empty(outEmpty),
        .almostFull(hold)
    );

    assign outValid = !outEmpty;
    assign outResultA = outPair[2*permPkg::RESULT_W-1:permPkg::RESULT_W];
    assign outResultB = outPair[permPkg::RESULT_W-1:0];

    outHoldsWhenStalled: assert property (@(posedge clk) disable iff (rst)
        (outValid && !outReady) |=> (outValid && $stable(outPair)))
        else $error("permDispatchTop: output changed while stalled");

endmodule

//--- permChecker.sv
`timescale 1ns/10ps

module permChecker (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          inValid,
    input  logic                          inReady,
    input  logic [permPkg::IN_W-1:0]      inData,
    input  logic                          outValid,
    input  logic                          outReady,
    input  logic [permPkg::RESULT_W-1:0]  outResultA,
    input  logic [permPkg::RESULT_W-1:0]  outResultB,
    output int                            pendingCount
);

    // Expected pairs with channel A above channel B
    logic [2*permPkg::RESULT_W-1:0] expected [$];
    logic [2*permPkg::RESULT_W-1:0] head;
    int errors = 0;
    int matched = 0;
    int sinceReset = 0;
    bit readySeen = 1'b0;
    bit backpressureSeen = 1'b0;

    // Count of one bits above the sum of the four 16-bit fields
    function automatic logic [permPkg::RESULT_W-1:0] laneReference(
        input logic [permPkg::WORD_W-1:0] word
    );
        logic [permPkg::COUNT_W-1:0] ones;
        logic [permPkg::SUM_W-1:0] sum;
        ones = '0;
        for (int b = 0; b < permPkg::WORD_W; b++) begin
            if (word[b]) begin
                ones = ones + 1'b1;
            end
        end
        sum = word[63:48] + word[47:32] + word[31:16] + word[15:0];
        return {ones, sum};
    endfunction

    always @(posedge clk) begin
        if (!rst) begin
            sinceReset = sinceReset + 1;
            if (inReady) begin
                readySeen = 1'b1;
            end
            if (sinceReset == 1 && outValid) begin
                errors++;
                $display("outValid was high in the first cycle after reset");
            end
            if (sinceReset == 4 && !readySeen) begin
                errors++;
                $display("inReady did not rise within 4 cycles after reset");
            end
            if (readySeen && inValid && !inReady) begin
                backpressureSeen = 1'b1;
            end
            if (inValid && inReady) begin
                expected.push_back({laneReference(inData[permPkg::IN_W-1:permPkg::WORD_W]),
                    laneReference(inData[permPkg::WORD_W-1:0])});
            end
            if (outValid && outReady) begin
                if (expected.size() == 0) begin
                    errors++;
                    $display("Result pair taken at %0t with no item expected", $time);
                end else begin
                    head = expected.pop_front();
                    if (outResultA !== head[2*permPkg::RESULT_W-1:permPkg::RESULT_W]) begin
                        errors++;
                        $display("FAIL outResultA expected %h actual %h",
                            head[2*permPkg::RESULT_W-1:permPkg::RESULT_W], outResultA);
                    end
                    if (outResultB !== head[permPkg::RESULT_W-1:0]) begin
                        errors++;
                        $display("FAIL outResultB expected %h actual %h",
                            head[permPkg::RESULT_W-1:0], outResultB);
                    end
                    matched++;
                end
            end
        end
        pendingCount = expected.size();
    end

    // Prints the closing line and returns the number of failures
    function automatic int reportTotals();
        if (!backpressureSeen) begin
            errors++;
            $display("inReady never dropped while the output was stalled");
        end
        $display("Totals: %0d errors, %0d pairs checked, %0d expected items left over",
            errors, matched, expected.size());
        return errors + expected.size();
    endfunction

endmodule

//--- permDispatchTb.sv
`timescale 1ns/10ps

module permDispatchTb;

    localparam int NUM_ITEMS = 400;
    localparam int TIMEOUT_CYCLES = 40 * NUM_ITEMS + 2000;
    localparam int STREAM_ITEMS = 120;
    localparam int GAP_ITEMS = 120;
    localparam int EDGE_ITEMS = 67;
    localparam int STALL_ITEMS = NUM_ITEMS - STREAM_ITEMS - GAP_ITEMS - EDGE_ITEMS;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic inValid = 1'b0;
    logic inReady;
    logic [permPkg::IN_W-1:0] inData = '0;
    logic outValid;
    logic outReady = 1'b0;
    logic [permPkg::RESULT_W-1:0] outResultA;
    logic [permPkg::RESULT_W-1:0] outResultB;
    int pendingCount;
    int seed = 81744;
    // 0 always ready, 1 random, 2 stalled
    int readyMode = 0;
    int cycleCount = 0;
    int failures;

    permDispatchTop u_permDispatchTop (
        .clk(clk), .rst(rst), .inValid(inValid), .inReady(inReady), .inData(inData),
        .outValid(outValid), .outReady(outReady),
        .outResultA(outResultA), .outResultB(outResultB)
    );

    permChecker u_permChecker (
        .clk(clk), .rst(rst), .inValid(inValid), .inReady(inReady), .inData(inData),
        .outValid(outValid), .outReady(outReady),
        .outResultA(outResultA), .outResultB(outResultB), .pendingCount(pendingCount)
    );

    initial begin
        forever #4 clk = ~clk;
    end

    function automatic logic [permPkg::IN_W-1:0] randomBeat();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    // Starts and ends 1 ns after a rising edge
    task automatic sendItem(input logic [permPkg::IN_W-1:0] data);
        inValid = 1'b1;
        inData = data;
        @(posedge clk);
        while (!inReady) begin
            @(posedge clk);
        end
        #1;
        inValid = 1'b0;
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            inData = randomBeat();
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        forever begin
            @(posedge clk);
            #1;
            if (readyMode == 0) begin
                outReady = 1'b1;
            end else if (readyMode == 1) begin
                outReady = ($random(seed) & 3) != 0;
            end else begin
                outReady = 1'b0;
            end
        end
    end

    initial begin
        while (cycleCount < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Run stopped by timeout after %0d cycles, %0d items still expected",
            cycleCount, pendingCount);
        failures = u_permChecker.reportTotals();
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        // Back-to-back items with the consumer always ready
        for (int i = 0; i < STREAM_ITEMS; i++) begin
            sendItem(randomBeat());
        end
        readyMode = 1;
        for (int i = 0; i < GAP_ITEMS; i++) begin
            idleCycles($random(seed) & 3);
            sendItem(randomBeat());
        end
        // Stall the consumer while the producer keeps offering
        readyMode = 2;
        fork
            for (int i = 0; i < STALL_ITEMS; i++) begin
                sendItem(randomBeat());
            end
            begin
                repeat (200) @(posedge clk);
                readyMode = 0;
            end
        join
        sendItem('0);
        sendItem('1);
        sendItem({{permPkg::WORD_W{1'b1}}, {permPkg::WORD_W{1'b0}}});
        for (int i = 0; i < permPkg::WORD_W; i++) begin
            sendItem({64'd1 << i, 64'd1 << (permPkg::WORD_W - 1 - i)});
        end
        while (pendingCount != 0) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);
        failures = u_permChecker.reportTotals();
        if (failures == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- vlog.f
permPkg.sv
syncFifo.sv
laneSelector.sv
laneWorker.sv
laneArray.sv
permDispatchTop.sv
permChecker.sv
permDispatchTb.sv

//--- Bender.yml
package:
  name: permDispatch

sources:
  - permPkg.sv
  - syncFifo.sv
  - laneSelector.sv
  - laneWorker.sv
  - laneArray.sv
  - permDispatchTop.sv
  - target: test
    files:
      - permChecker.sv
      - permDispatchTb.sv
